// ==== hw/dac_format_pkg.sv ====
/* output format of the DAC datapath; every channel emits PARALLEL_SAMPLES
   two's complement samples per dac_clk cycle with no back-pressure */
package dac_format_pkg;

  // independent waveform channels
  localparam int CHANNELS = 2;

  // samples per channel per dac_clk cycle
  localparam int PARALLEL_SAMPLES = 4;

  // width of one output sample, two's complement
  localparam int SAMPLE_WIDTH = 12;

  // cycles from a registered sample phase to its output sample
  // the shaper and the crossing detector both follow this depth
  localparam int PIPE_LATENCY = 2;

  // a batch on the DAC bus is CHANNELS x PARALLEL_SAMPLES words
  // sample 0 of a batch is the oldest in time
  // channel c sample s sits at index [c][s] on the packed buses

  // one sample per cycle per lane means the DAC drains a batch
  // every cycle, so nothing in the generator can stall

  // valid is a level shared by all channels
  // trigger is one bit per channel

endpackage

// ==== hw/phase_pkg.sv ====
/* phase word of the triangle generator; one full wrap of PHASE_BITS is one
   period, so the frequency step is f_sample / 2^PHASE_BITS */
package phase_pkg;

  // accumulator width, one wrap is one period
  localparam int PHASE_BITS = 24;

  // mid-scale code of the full-precision fold
  // this is the most negative two's complement value
  localparam logic [PHASE_BITS-1:0] PHASE_MID = {1'b1, {(PHASE_BITS-1){1'b0}}};

  // decoded view of a phase word
  // half = 0 is the rising half of the period
  // quarter flips where the wave crosses zero
  typedef struct packed {
    logic                  half;
    logic                  quarter;
    logic [PHASE_BITS-3:0] fraction;
  } phase_fields_t;

  // raw is used for the accumulator arithmetic
  // field is used by the shaper and the crossing detector
  typedef union packed {
    logic [PHASE_BITS-1:0] raw;
    phase_fields_t         field;
  } phase_word_u;

  // within the rising half the quarter bit goes 0 to 1 at the
  // upward zero crossing of the folded wave

  // in the falling half it goes 0 to 1 at the downward crossing

endpackage

// ==== hw/phase_increment_table.sv ====
/* increments load only on the phase_inc_load strobe and are held after;
   multiples wrap modulo 2^PHASE_BITS */
`timescale 1ns/1ns
module phase_increment_table (
  input  logic dac_clk,
  input  logic dac_reset,
  input  logic [dac_format_pkg::CHANNELS-1:0][phase_pkg::PHASE_BITS-1:0] phase_inc,
  input  logic phase_inc_load,
  output logic [dac_format_pkg::CHANNELS-1:0]
               [dac_format_pkg::PARALLEL_SAMPLES-1:0]
               [phase_pkg::PHASE_BITS-1:0] inc_multiple
);

  import dac_format_pkg::*;
  import phase_pkg::*;

  // entry s holds (s+1) times the channel increment
  // the last entry is the step of a whole batch
  // products are taken once at load time so the
  // per-cycle accumulation only has adders in it

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      // zero increment holds every phase at zero
      inc_multiple <= '0;
    end else if (phase_inc_load) begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
          // keep only the low bits, the phase wraps anyway
          inc_multiple[ch][s] <= PHASE_BITS'(phase_inc[ch] * (s + 1));
        end
      end
    end
  end

  // new multiples are visible right after the load edge
  // the accumulator picks them up on the following edge
  // so a load at edge e first shows in the phases of edge e+1

  // all channels reload together
  // a channel that should keep its rate has to be given
  // the same increment again on the bus

  // note the table is not cleared between loads
  // it simply overwrites every entry at once

endmodule

// ==== hw/phase_accumulator.sv ====
/* phases start at zero after reset; sample_valid marks the phases as
   meaningful from the second edge after reset is released */
`timescale 1ns/1ns
module phase_accumulator (
  input  logic dac_clk,
  input  logic dac_reset,
  input  logic [dac_format_pkg::CHANNELS-1:0]
               [dac_format_pkg::PARALLEL_SAMPLES-1:0]
               [phase_pkg::PHASE_BITS-1:0] inc_multiple,
  output phase_pkg::phase_word_u [dac_format_pkg::CHANNELS-1:0]
                                 [dac_format_pkg::PARALLEL_SAMPLES-1:0] sample_phase,
  output logic sample_valid
);

  import dac_format_pkg::*;
  import phase_pkg::*;

  // phase of sample 0 of the batch being formed
  logic [CHANNELS-1:0][PHASE_BITS-1:0] batch_phase;

  // warm-up shift register, fills with ones after reset
  logic [1:0] warmup;

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      batch_phase  <= '0;
      sample_phase <= '0;
      warmup       <= '0;
    end else begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        // step a whole batch at once
        batch_phase[ch] <= batch_phase[ch] + inc_multiple[ch][PARALLEL_SAMPLES-1];

        // sample 0 is the batch phase itself
        sample_phase[ch][0].raw <= batch_phase[ch];

        // later samples add the matching multiple
        // all of them use the batch phase from before this edge
        for (int s = 1; s < PARALLEL_SAMPLES; s++) begin
          sample_phase[ch][s].raw <= batch_phase[ch] + inc_multiple[ch][s-1];
        end
      end
      warmup <= {warmup[0], 1'b1};
    end
  end

  // high from the second edge after reset onwards
  assign sample_valid = warmup[1];

  // wrap-around of batch_phase is the period boundary
  // no special handling is needed since the adders are modulo

  // the batch phase and its samples never stop stepping
  // a zero increment simply holds the wave at one point

  // a change of increment takes effect on the next edge
  // without any phase jump, since only the step changes

endmodule

// ==== hw/triangle_shaper.sv ====
/* two-stage fold of phase into a full-scale triangle; output samples are
   the top SAMPLE_WIDTH bits, truncated and not rounded */
`timescale 1ns/1ns
module triangle_shaper (
  input  logic dac_clk,
  input  logic dac_reset,
  input  phase_pkg::phase_word_u [dac_format_pkg::CHANNELS-1:0]
                                 [dac_format_pkg::PARALLEL_SAMPLES-1:0] sample_phase,
  input  logic sample_valid,
  output logic [dac_format_pkg::CHANNELS-1:0]
               [dac_format_pkg::PARALLEL_SAMPLES-1:0]
               [dac_format_pkg::SAMPLE_WIDTH-1:0] dac_data,
  output logic dac_valid
);

  import dac_format_pkg::*;
  import phase_pkg::*;

  logic [CHANNELS-1:0][PARALLEL_SAMPLES-1:0][PHASE_BITS-1:0] fold_next;
  logic [CHANNELS-1:0][PARALLEL_SAMPLES-1:0][PHASE_BITS-1:0] fold;
  logic [PIPE_LATENCY-1:0] valid_pipe;

  // fold the phase into a two's complement ramp up then down
  always_comb begin
    logic [PHASE_BITS-1:0] ramp;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
        // twice the phase below the half bit
        ramp = {sample_phase[ch][s].field.quarter, sample_phase[ch][s].field.fraction, 1'b0};
        if (!sample_phase[ch][s].field.half) begin
          // rising half, minimum up to maximum
          fold_next[ch][s] = PHASE_MID + ramp;
        end else begin
          // falling half, maximum down to minimum
          fold_next[ch][s] = PHASE_MID - 1'b1 - ramp;
        end
      end
    end
  end

  // stage 1 keeps full precision
  always_ff @(posedge dac_clk) begin
    fold <= fold_next;
  end

  // stage 2 truncates, zero until the phases are meaningful
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      valid_pipe <= '0;
      dac_data   <= '0;
    end else begin
      valid_pipe <= {valid_pipe[PIPE_LATENCY-2:0], sample_valid};
      for (int ch = 0; ch < CHANNELS; ch++) begin
        for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
          dac_data[ch][s] <= valid_pipe[PIPE_LATENCY-2] ?
                             fold[ch][s][PHASE_BITS-1 -: SAMPLE_WIDTH] : '0;
        end
      end
    end
  end

  assign dac_valid = valid_pipe[PIPE_LATENCY-1];

endmodule

// ==== hw/rising_crossing_detect.sv ====
/* trigger is exact only while the phase moves less than a quarter period
   per batch; faster waves can miss or misplace the crossing */
`timescale 1ns/1ns
module rising_crossing_detect (
  input  logic dac_clk,
  input  logic dac_reset,
  input  phase_pkg::phase_word_u [dac_format_pkg::CHANNELS-1:0]
                                 [dac_format_pkg::PARALLEL_SAMPLES-1:0] sample_phase,
  output logic [dac_format_pkg::CHANNELS-1:0] dac_trigger
);

  import dac_format_pkg::*;
  import phase_pkg::*;

  // decoded phase bits of the current batch
  logic [CHANNELS-1:0][PARALLEL_SAMPLES-1:0] half_bits;
  logic [CHANNELS-1:0][PARALLEL_SAMPLES-1:0] quarter_bits;

  // quarter bits of the previous batch
  logic [CHANNELS-1:0][PARALLEL_SAMPLES-1:0] quarter_prev;

  // stage 1 flags
  logic [CHANNELS-1:0] rising;
  logic [CHANNELS-1:0] crossing;

  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
        half_bits[ch][s]    = sample_phase[ch][s].field.half;
        quarter_bits[ch][s] = sample_phase[ch][s].field.quarter;
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      quarter_prev <= '0;
      rising       <= '0;
      crossing     <= '0;
      dac_trigger  <= '0;
    end else begin
      quarter_prev <= quarter_bits;
      for (int ch = 0; ch < CHANNELS; ch++) begin
        // whole batch in the rising half
        rising[ch] <= ~|half_bits[ch];
        // mixed quarter bits put the crossing inside this batch
        // all ones after all zeros puts it on the batch boundary
        crossing[ch] <= (|quarter_bits[ch] & ~&quarter_bits[ch]) |
                        (&quarter_bits[ch] & ~|quarter_prev[ch]);
      end
      // stage 2 lines up with dac_data
      dac_trigger <= rising & crossing;
    end
  end

  // the boundary case flags the batch that starts past zero
  // so one crossing gives exactly one trigger either way

  // a falling half batch also flips quarter, the rising
  // flag keeps that downward crossing from triggering

endmodule

// ==== hw/triangle_gen.sv ====
/* triangle source, one batch per channel per dac_clk; a load reaches the
   outputs 3 cycles later and dac_trigger is aligned with dac_data */
`timescale 1ns/1ns
module triangle_gen (
  input  logic dac_clk,
  input  logic dac_reset,
  input  logic [dac_format_pkg::CHANNELS-1:0][phase_pkg::PHASE_BITS-1:0] phase_inc,
  input  logic phase_inc_load,
  output logic [dac_format_pkg::CHANNELS-1:0]
               [dac_format_pkg::PARALLEL_SAMPLES-1:0]
               [dac_format_pkg::SAMPLE_WIDTH-1:0] dac_data,
  output logic dac_valid,
  output logic [dac_format_pkg::CHANNELS-1:0] dac_trigger
);

  import dac_format_pkg::*;
  import phase_pkg::*;

  // multiples of each increment
  logic [CHANNELS-1:0][PARALLEL_SAMPLES-1:0][PHASE_BITS-1:0] inc_multiple;

  // per-sample phases shared by the shaper and the detector
  phase_word_u [CHANNELS-1:0][PARALLEL_SAMPLES-1:0] sample_phase;
  logic sample_valid;

  phase_increment_table u_inc_table (
    .dac_clk        (dac_clk),
    .dac_reset      (dac_reset),
    .phase_inc      (phase_inc),
    .phase_inc_load (phase_inc_load),
    .inc_multiple   (inc_multiple)
  );

  phase_accumulator u_accumulator (
    .dac_clk      (dac_clk),
    .dac_reset    (dac_reset),
    .inc_multiple (inc_multiple),
    .sample_phase (sample_phase),
    .sample_valid (sample_valid)
  );

  // both consumers take PIPE_LATENCY cycles
  triangle_shaper u_shaper (
    .dac_clk      (dac_clk),
    .dac_reset    (dac_reset),
    .sample_phase (sample_phase),
    .sample_valid (sample_valid),
    .dac_data     (dac_data),
    .dac_valid    (dac_valid)
  );

  rising_crossing_detect u_crossing (
    .dac_clk      (dac_clk),
    .dac_reset    (dac_reset),
    .sample_phase (sample_phase),
    .dac_trigger  (dac_trigger)
  );

endmodule

// ==== verification/triangle_checker.sv ====
/* cycle model of triangle_gen, compared with the DUT at every falling edge;
   counts mismatches, checks and per-channel triggers for the testbench */
`timescale 1ns/1ns
module triangle_checker (
  input logic dac_clk,
  input logic dac_reset,
  input logic [dac_format_pkg::CHANNELS-1:0][phase_pkg::PHASE_BITS-1:0] phase_inc,
  input logic phase_inc_load,
  input logic [dac_format_pkg::CHANNELS-1:0]
              [dac_format_pkg::PARALLEL_SAMPLES-1:0]
              [dac_format_pkg::SAMPLE_WIDTH-1:0] dac_data,
  input logic dac_valid,
  input logic [dac_format_pkg::CHANNELS-1:0] dac_trigger
);

  import dac_format_pkg::*;
  import phase_pkg::*;

  // latched increment and phase of the next batch
  logic [CHANNELS-1:0][PHASE_BITS-1:0] inc_now;
  logic [CHANNELS-1:0][PHASE_BITS-1:0] batch_now;
  // sample phases of the last four edges, index 0 is the newest
  logic [CHANNELS-1:0][PARALLEL_SAMPLES-1:0][PHASE_BITS-1:0] phase_hist [0:3];
  int edges_run;
  int error_count;
  int checks_done;
  int dut_triggers [0:CHANNELS-1];
  int model_triggers [0:CHANNELS-1];

  // advance the model by one dac_clk edge with the inputs seen at that edge
  function void step_model(input logic rst, input logic load,
                           input logic [CHANNELS-1:0][PHASE_BITS-1:0] inc_in);
    if (rst) begin
      inc_now   = '0;
      batch_now = '0;
      for (int i = 0; i < 4; i++) phase_hist[i] = '0;
      edges_run = 0;
    end else begin
      for (int i = 3; i > 0; i--) phase_hist[i] = phase_hist[i-1];
      for (int ch = 0; ch < CHANNELS; ch++) begin
        // sample s of a batch lies s increments past the batch phase
        for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
          phase_hist[0][ch][s] = batch_now[ch] + s * inc_now[ch];
        end
        batch_now[ch] = batch_now[ch] + PARALLEL_SAMPLES * inc_now[ch];
      end
      // a load is used from the following edge on
      if (load) inc_now = inc_in;
      if (edges_run < 1000) edges_run++;
    end
  endfunction

  // ideal triangle, minimum at phase 0, maximum at half period
  function logic [SAMPLE_WIDTH-1:0] triangle_code(input logic [PHASE_BITS-1:0] phase);
    longint half_span;
    longint p;
    longint level;
    logic [SAMPLE_WIDTH-1:0] code;
    half_span = 64'd1 << (PHASE_BITS - 1);
    p = phase;
    if (p < half_span) level = 2 * p - half_span;
    else level = half_span - 1 - 2 * (p - half_span);
    // top bits of the two's complement level, floor division
    code = level >>> (PHASE_BITS - SAMPLE_WIDTH);
    return code;
  endfunction

  // rising batch holding the quarter-bit flip, inside or on its leading edge
  function logic trigger_expected(input logic [PARALLEL_SAMPLES-1:0][PHASE_BITS-1:0] cur,
                                  input logic [PARALLEL_SAMPLES-1:0][PHASE_BITS-1:0] prev);
    logic rising;
    logic q_any;
    logic q_all;
    logic prev_any;
    rising   = 1'b1;
    q_any    = 1'b0;
    q_all    = 1'b1;
    prev_any = 1'b0;
    for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
      if (cur[s][PHASE_BITS-1]) rising = 1'b0;
      q_any    = q_any | cur[s][PHASE_BITS-2];
      q_all    = q_all & cur[s][PHASE_BITS-2];
      prev_any = prev_any | prev[s][PHASE_BITS-2];
    end
    return rising & ((q_any & ~q_all) | (q_all & ~prev_any));
  endfunction

  initial begin
    step_model(1'b1, 1'b0, '0);
    error_count = 0;
    checks_done = 0;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      dut_triggers[ch]   = 0;
      model_triggers[ch] = 0;
    end
  end

  // outputs of the last edge are stable here, inputs are those of the next edge
  always @(negedge dac_clk) begin : compare_batch
    logic valid_exp;
    logic trig_exp;
    logic [SAMPLE_WIDTH-1:0] code_exp;
    // two warm-up edges, then the shaper depth
    valid_exp = (edges_run >= PIPE_LATENCY + 2);
    checks_done++;
    if (dac_valid !== valid_exp) begin
      $display("FAILED t=%0t dac_valid expected %b actual %b", $time, valid_exp, dac_valid);
      error_count++;
    end
    for (int ch = 0; ch < CHANNELS; ch++) begin
      trig_exp = trigger_expected(phase_hist[PIPE_LATENCY][ch],
                                  phase_hist[PIPE_LATENCY+1][ch]);
      if (trig_exp) model_triggers[ch]++;
      if (dac_trigger[ch] === 1'b1) dut_triggers[ch]++;
      if (dac_trigger[ch] !== trig_exp) begin
        $display("FAILED t=%0t dac_trigger[%0d] expected %b actual %b",
                 $time, ch, trig_exp, dac_trigger[ch]);
        error_count++;
      end
      for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
        code_exp = valid_exp ? triangle_code(phase_hist[PIPE_LATENCY][ch][s]) : '0;
        if (dac_data[ch][s] !== code_exp) begin
          $display("FAILED t=%0t dac_data[%0d][%0d] expected %h actual %h",
                   $time, ch, s, code_exp, dac_data[ch][s]);
          error_count++;
        end
      end
    end
    step_model(dac_reset, phase_inc_load, phase_inc);
  end

endmodule

// ==== verification/triangle_gen_tb.sv ====
/* drives triangle_gen with LFSR increments kept below a quarter period per
   batch; sample and trigger values are compared in triangle_checker */
`timescale 1ns/1ns
module triangle_gen_tb;

  import dac_format_pkg::*;
  import phase_pkg::*;

  logic dac_clk;
  logic dac_reset;
  logic [CHANNELS-1:0][PHASE_BITS-1:0] phase_inc;
  logic phase_inc_load;
  logic [CHANNELS-1:0][PARALLEL_SAMPLES-1:0][SAMPLE_WIDTH-1:0] dac_data;
  logic dac_valid;
  logic [CHANNELS-1:0] dac_trigger;

  logic [15:0] lfsr_state;
  int tb_errors;
  int tests_run;
  int tests_failed;

  triangle_gen UUT (
    .dac_clk        (dac_clk),
    .dac_reset      (dac_reset),
    .phase_inc      (phase_inc),
    .phase_inc_load (phase_inc_load),
    .dac_data       (dac_data),
    .dac_valid      (dac_valid),
    .dac_trigger    (dac_trigger)
  );

  triangle_checker u_checker (
    .dac_clk        (dac_clk),
    .dac_reset      (dac_reset),
    .phase_inc      (phase_inc),
    .phase_inc_load (phase_inc_load),
    .dac_data       (dac_data),
    .dac_valid      (dac_valid),
    .dac_trigger    (dac_trigger)
  );

  // 10 ns period
  always #5 dac_clk = ~dac_clk;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function logic lfsr_step();
    logic feedback;
    feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], feedback};
    return feedback;
  endfunction

  // one LFSR step per bit taken
  function logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) value = {value[30:0], lfsr_step()};
    return value;
  endfunction

  function int total_errors();
    return u_checker.error_count + tb_errors;
  endfunction

  task value_mismatch(input string name, input longint expected, input longint actual);
    $display("FAILED t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
    tb_errors++;
  endtask

  task report_test(input int num, input string name, input int start_errors);
    int errs;
    errs = total_errors() - start_errors;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %0d %s: %0d errors", num, name, errs);
  endtask

  // one-cycle load strobe for both channels
  task load_increments(input logic [PHASE_BITS-1:0] inc0, input logic [PHASE_BITS-1:0] inc1);
    @(posedge dac_clk);
    phase_inc      <= {inc1, inc0};
    phase_inc_load <= 1'b1;
    @(posedge dac_clk);
    phase_inc_load <= 1'b0;
  endtask

  task run_cycles(input int count);
    repeat (count) @(posedge dac_clk);
  endtask

  // counts edges until dac_valid while the outputs stay zero
  task wait_for_valid(input int limit, output int edges, output logic seen);
    edges = 0;
    seen  = 1'b0;
    while (!seen && edges < limit) begin
      @(posedge dac_clk);
      edges++;
      @(negedge dac_clk);
      if (dac_valid === 1'b1) seen = 1'b1;
      else if (dac_data !== '0) value_mismatch("dac_data before valid", 0, dac_data[0][0]);
      else if (dac_trigger !== '0) value_mismatch("dac_trigger before valid", 0, dac_trigger);
    end
  endtask

  // one upward crossing per period so the phase travel sets the count
  task check_trigger_count(input int ch, input logic [PHASE_BITS-1:0] inc,
                           input int count, input int window);
    longint advance;
    longint low;
    advance = window;
    advance = advance * PARALLEL_SAMPLES * inc;
    low = advance >> PHASE_BITS;
    if (count < low) value_mismatch($sformatf("dac_trigger[%0d] count", ch), low, count);
    else if (count > low + 1)
      value_mismatch($sformatf("dac_trigger[%0d] count", ch), low + 1, count);
  endtask

  initial begin : test_sequence
    logic [PHASE_BITS-1:0] inc_a;
    logic [PHASE_BITS-1:0] inc_b;
    int edges;
    logic seen;
    int start_errs;
    int dut_start [0:CHANNELS-1];
    int model_start [0:CHANNELS-1];
    dac_clk        = 1'b0;
    dac_reset      = 1'b1;
    phase_inc      = '0;
    phase_inc_load = 1'b0;
    lfsr_state     = 16'd61;
    tb_errors      = 0;
    tests_run      = 0;
    tests_failed   = 0;
    repeat (4) @(posedge dac_clk);
    dac_reset <= 1'b0;

    // zero outputs through warm-up and valid on the 4th edge
    start_errs = total_errors();
    wait_for_valid(20, edges, seen);
    if (!seen) begin
      $display("timeout: dac_valid never rose within 20 cycles after reset");
      tb_errors++;
    end else if (edges != PIPE_LATENCY + 2) begin
      value_mismatch("dac_valid rise edge", PIPE_LATENCY + 2, edges);
    end
    report_test(1, "reset and warm-up", start_errs);

    if (seen) begin
      // periods of 8 to 16 cycles sweep both halves and wrap many times
      start_errs = total_errors();
      inc_a = 24'h40000 + random_bits(18);
      inc_b = 24'h40000 + random_bits(18);
      load_increments(inc_a, inc_b);
      run_cycles(300);
      report_test(2, "constant increment", start_errs);

      // reload while running with the 3-cycle latency in the model
      start_errs = total_errors();
      load_increments(24'h1 + random_bits(18), 24'h1 + random_bits(18));
      run_cycles(40);
      report_test(3, "increment reload", start_errs);

      // periods of 256 to 512 cycles
      start_errs = total_errors();
      inc_a = 24'h2000 + random_bits(13);
      inc_b = 24'h2000 + random_bits(13);
      load_increments(inc_a, inc_b);
      run_cycles(PIPE_LATENCY + 2);
      for (int ch = 0; ch < CHANNELS; ch++) dut_start[ch] = u_checker.dut_triggers[ch];
      run_cycles(2048);
      check_trigger_count(0, inc_a, u_checker.dut_triggers[0] - dut_start[0], 2048);
      check_trigger_count(1, inc_b, u_checker.dut_triggers[1] - dut_start[1], 2048);
      report_test(4, "trigger per period", start_errs);

      // distinct rates on the two channels
      start_errs = total_errors();
      inc_a = 24'h800 + random_bits(17);
      inc_b = 24'h800 + random_bits(17);
      if (inc_a == inc_b) inc_b = inc_b ^ 24'h100;
      load_increments(inc_a, inc_b);
      run_cycles(PIPE_LATENCY + 2);
      for (int ch = 0; ch < CHANNELS; ch++) begin
        dut_start[ch]   = u_checker.dut_triggers[ch];
        model_start[ch] = u_checker.model_triggers[ch];
      end
      run_cycles(1500);
      for (int ch = 0; ch < CHANNELS; ch++) begin
        if (u_checker.dut_triggers[ch] - dut_start[ch] !=
            u_checker.model_triggers[ch] - model_start[ch]) begin
          value_mismatch($sformatf("dac_trigger[%0d] count", ch),
                         u_checker.model_triggers[ch] - model_start[ch],
                         u_checker.dut_triggers[ch] - dut_start[ch]);
        end
      end
      report_test(5, "independent channels", start_errs);
    end

    $display("tests run %0d, tests failed %0d, batch checks %0d, errors %0d",
             tests_run, tests_failed, u_checker.checks_done, total_errors());
    if (total_errors() == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
hw/dac_format_pkg.sv
hw/phase_pkg.sv
hw/phase_increment_table.sv
hw/phase_accumulator.sv
hw/triangle_shaper.sv
hw/rising_crossing_detect.sv
hw/triangle_gen.sv
verification/triangle_checker.sv
verification/triangle_gen_tb.sv
